//--- common/div_pkg.sv
package div_pkg;

  localparam int RS_SIZE  = 16;
  localparam int IDX_W    = 4;
  localparam int TAG_W    = 8;
  localparam int NUM_WAKE = 7;

  // broadcast port positions in the wakeup array
  localparam int WAKE_ALU    = 0;
  localparam int WAKE_MUL    = 1;
  localparam int WAKE_DIV    = 2;
  localparam int WAKE_LOAD   = 3;
  localparam int WAKE_BRANCH = 4;
  localparam int WAKE_P      = 5;
  localparam int WAKE_CSR    = 6;

  typedef logic [TAG_W-1:0] phys_tag_t;

  // 60 bits in the same order as the issued word
  typedef struct packed {
    logic [31:0] pc;
    phys_tag_t   rd;
    logic [3:0]  op;
    phys_tag_t   src1;
    phys_tag_t   src2;
  } rs_payload_t;

  typedef struct packed {
    logic        start;
    rs_payload_t payload;
    logic [1:0]  src_ready;  // bit 0 src1, bit 1 src2
  } dispatch_t;

  typedef struct packed {
    logic      valid;
    phys_tag_t tag;
  } wake_t;

  typedef wake_t [NUM_WAKE-1:0] wake_bus_t;

  // 61-bit issue word to the divider
  typedef struct packed {
    logic        valid;
    rs_payload_t payload;
  } div_issue_t;

endpackage

//--- div_rs/div_rs_ctrl.sv
`timescale 1ns/10ps

module div_rs_ctrl
  import div_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush,
  input  logic               start,
  input  logic               div_busy,
  input  logic               grant_found,
  input  logic [IDX_W-1:0]   grant_idx,
  input  rs_payload_t        grant_payload,
  output logic [RS_SIZE-1:0] occupied,
  output logic               alloc_en,
  output logic [IDX_W-1:0]   alloc_idx,
  output div_issue_t         issue,
  output logic               full
);

  logic               issue_fire;
  logic [RS_SIZE-1:0] occ_next;
  logic               issue_valid;
  rs_payload_t        issue_payload;

  // lowest free slot
  always_comb begin
    alloc_idx = '0;
    for (int i = RS_SIZE - 1; i >= 0; i--) begin
      if (!occupied[i]) begin
        alloc_idx = IDX_W'(i);
      end
    end
  end

  assign alloc_en   = start & ~full;          // dispatch while full is dropped
  assign issue_fire = grant_found & ~div_busy;

  // alloc and issue never hit the same slot
  always_comb begin
    occ_next = occupied;
    if (issue_fire) begin
      occ_next[grant_idx] = 1'b0;
    end
    if (alloc_en) begin
      occ_next[alloc_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      occupied    <= '0;
      full        <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      occupied    <= occ_next;
      full        <= &occ_next;
      issue_valid <= issue_fire;  // one cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (issue_fire) begin
      issue_payload <= grant_payload;
    end
  end

  assign issue = '{valid: issue_valid, payload: issue_payload};

endmodule

//--- div_rs/div_rs_select.sv
`timescale 1ns/10ps

module div_rs_select
  import div_pkg::*;
(
  input  logic [RS_SIZE-1:0] ready,
  input  logic [RS_SIZE-1:0] occupied,
  output logic [IDX_W-1:0]   grant_idx,
  output logic               grant_found
);

  logic [RS_SIZE-1:0] eligible;

  // ready bits of free slots may be stale
  assign eligible = ready & occupied;

  // scan from the top so the lowest index wins
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int i = RS_SIZE - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        grant_found = 1'b1;
        grant_idx   = IDX_W'(i);
      end
    end
  end

endmodule

//--- div_rs/div_rs_store.sv
`timescale 1ns/10ps

module div_rs_store
  import div_pkg::*;
(
  input  logic             clk,
  input  logic             alloc_en,
  input  logic [IDX_W-1:0] alloc_idx,
  input  dispatch_t        dispatch,
  input  logic [IDX_W-1:0] grant_idx,
  output rs_payload_t      grant_payload
);

  // pc, rd, op and source tags per slot
  rs_payload_t mem [RS_SIZE];

  always_ff @(posedge clk) begin
    if (alloc_en) begin
      mem[alloc_idx] <= dispatch.payload;
    end
  end

  assign grant_payload = mem[grant_idx];  // async read for the issue register

endmodule

//--- div_rs/div_rs_wakeup.sv
`timescale 1ns/10ps

module div_rs_wakeup
  import div_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               alloc_en,
  input  logic [IDX_W-1:0]   alloc_idx,
  input  dispatch_t          dispatch,
  input  wake_bus_t          wake,
  output logic [RS_SIZE-1:0] ready
);

  phys_tag_t          src1_tag [RS_SIZE];
  phys_tag_t          src2_tag [RS_SIZE];
  logic [RS_SIZE-1:0] rdy1;
  logic [RS_SIZE-1:0] rdy2;
  logic [RS_SIZE-1:0] hit1;
  logic [RS_SIZE-1:0] hit2;
  logic               disp_hit1;
  logic               disp_hit2;

  // any valid broadcast carrying this tag
  function automatic logic tag_hit(input phys_tag_t tag, input wake_bus_t bus);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < NUM_WAKE; p++) begin
      if (bus[p].valid && bus[p].tag == tag) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  always_comb begin
    for (int i = 0; i < RS_SIZE; i++) begin
      hit1[i] = tag_hit(src1_tag[i], wake);
      hit2[i] = tag_hit(src2_tag[i], wake);
    end
  end

  // bypass for a result landing in the dispatch cycle
  assign disp_hit1 = tag_hit(dispatch.payload.src1, wake);
  assign disp_hit2 = tag_hit(dispatch.payload.src2, wake);

  always_ff @(posedge clk) begin
    if (alloc_en) begin
      src1_tag[alloc_idx] <= dispatch.payload.src1;
      src2_tag[alloc_idx] <= dispatch.payload.src2;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy1 <= '0;
      rdy2 <= '0;
    end else begin
      rdy1 <= rdy1 | hit1;
      rdy2 <= rdy2 | hit2;
      if (alloc_en) begin  // new entry overrides stale bits
        rdy1[alloc_idx] <= dispatch.src_ready[0] | disp_hit1;
        rdy2[alloc_idx] <= dispatch.src_ready[1] | disp_hit2;
      end
    end
  end

  assign ready = rdy1 & rdy2;

endmodule

//--- hw/div_rs_top.sv
`timescale 1ns/10ps

module div_rs_top
  import div_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  dispatch_t  dispatch,
  input  wake_bus_t  wake,
  input  logic       flush,     // exception or mret
  input  logic       div_busy,
  output div_issue_t issue,
  output logic       full
);

  logic               alloc_en;
  logic [IDX_W-1:0]   alloc_idx;
  logic [RS_SIZE-1:0] occupied;
  logic [RS_SIZE-1:0] ready;
  logic [IDX_W-1:0]   grant_idx;
  logic               grant_found;
  rs_payload_t        grant_payload;

  div_rs_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .start         (dispatch.start),
    .div_busy      (div_busy),
    .grant_found   (grant_found),
    .grant_idx     (grant_idx),
    .grant_payload (grant_payload),
    .occupied      (occupied),
    .alloc_en      (alloc_en),
    .alloc_idx     (alloc_idx),
    .issue         (issue),
    .full          (full)
  );

  div_rs_store u_store (
    .clk           (clk),
    .alloc_en      (alloc_en),
    .alloc_idx     (alloc_idx),
    .dispatch      (dispatch),
    .grant_idx     (grant_idx),
    .grant_payload (grant_payload)
  );

  div_rs_wakeup u_wakeup (
    .clk       (clk),
    .rst_n     (rst_n),
    .alloc_en  (alloc_en),
    .alloc_idx (alloc_idx),
    .dispatch  (dispatch),
    .wake      (wake),
    .ready     (ready)
  );

  div_rs_select u_select (
    .ready       (ready),
    .occupied    (occupied),
    .grant_idx   (grant_idx),
    .grant_found (grant_found)
  );

endmodule

//--- tb/div_rs_cases.txt
# start pc rd op src1 src2 src_ready | wake valid/tag x7 (alu mul div load branch p csr)
# | flush busy | expected issue valid pc rd op src1 src2 | expected full
# expected columns are the outputs seen in that cycle, before its inputs are clocked
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0100 10 3 01 02 3  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0100 10 3 01 02  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0200 40 1 30 31 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  1 30 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  1 31 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0204 41 2 32 33 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0200 40 1 30 31  0
0 0 00 0 00 00 0  0 00 1 32 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 1 33 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0208 42 3 34 35 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0204 41 2 32 33  0
0 0 00 0 00 00 0  0 00 0 00 1 34 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 1 35 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 020c 43 4 36 37 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0208 42 3 34 35  0
0 0 00 0 00 00 0  0 00 0 00 0 00 1 36 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 1 37 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0210 44 5 38 39 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 020c 43 4 36 37  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 1 38 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 1 39 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0214 45 6 3a 3b 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0210 44 5 38 39  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 1 3a 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 1 3b 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0218 46 7 3c 3d 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0214 45 6 3a 3b  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 1 3c  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 1 3d  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0300 50 8 60 61 0  1 60 0 00 0 00 1 61 0 00 0 00 0 00  0 0  1 0218 46 7 3c 3d  0
1 0304 51 9 62 63 1  0 00 0 00 0 00 0 00 0 00 0 00 1 63  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0300 50 8 60 61  0
1 0400 60 1 70 71 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0304 51 9 62 63  0
1 0404 61 2 70 71 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0408 62 3 70 71 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 040c 63 4 70 71 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 1 70 1 71 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0400 60 1 70 71  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0404 61 2 70 71  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0408 62 3 70 71  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 040c 63 4 70 71  0
1 0500 70 a 01 02 3  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 1  0 0 00 0 00 00  0
1 0504 71 b 01 02 3  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 1  0 0 00 0 00 00  0
1 0508 72 c 03 04 3  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 1  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 1  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 1  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 050c 73 d 05 06 3  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0500 70 a 01 02  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 1  1 0504 71 b 01 02  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 050c 73 d 05 06  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0508 72 c 03 04  0
1 0600 80 0 01 a0 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0604 81 1 01 a1 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0608 82 2 01 a2 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 060c 83 3 01 a3 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0610 84 4 01 a4 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0614 85 5 01 a5 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0618 86 6 01 a6 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 061c 87 7 01 a7 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0620 88 8 01 a8 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0624 89 9 01 a9 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0628 8a a 01 aa 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 062c 8b b 01 ab 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0630 8c c 01 ac 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0634 8d d 01 ad 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0638 8e e 01 ae 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 063c 8f f 01 af 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 1 a5 0 00 0 00  0 0  0 0 00 0 00 00  1
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  1
1 0700 90 1 01 b0 1  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0614 85 5 01 a5  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  1 0  0 0 00 0 00 00  1
0 0 00 0 00 00 0  1 a0 1 a1 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0800 a0 2 05 06 3  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0800 a0 2 05 06  0
1 0900 b1 3 07 08 3  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  1 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
1 0a00 c0 4 11 12 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 1 11 1 12  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  1 0a00 c0 4 11 12  0
0 0 00 0 00 00 0  0 00 0 00 0 00 0 00 0 00 0 00 0 00  0 0  0 0 00 0 00 00  0

//--- tb/div_rs_sva.sv
`timescale 1ns/10ps

module div_rs_sva
  import div_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input dispatch_t  dispatch,
  input logic       flush,
  input logic       div_busy,
  input div_issue_t issue,
  input logic       full
);

  // a dispatch into a full station would be lost
  no_dispatch_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    dispatch.start |-> !full
  ) else $error("dispatch arrived while the station was full");

  issue_cleared: assert property (
    @(posedge clk) (!rst_n || flush) |=> !issue.valid
  ) else $error("issue valid in the cycle after reset or flush");

  busy_holds_issue: assert property (
    @(posedge clk) disable iff (!rst_n)
    div_busy |=> !issue.valid  // divider not taking work
  ) else $error("issue valid in the cycle after div_busy was high");

endmodule

bind div_rs_top div_rs_sva u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .dispatch (dispatch),
  .flush    (flush),
  .div_busy (div_busy),
  .issue    (issue),
  .full     (full)
);

//--- tb/div_rs_tb.sv
`timescale 1ns/10ps

module div_rs_tb
  import div_pkg::*;
();

  logic       clk;
  logic       rst_n;
  dispatch_t  dispatch;
  wake_bus_t  wake;
  logic       flush;
  logic       div_busy;
  div_issue_t issue;
  logic       full;

  // one entry per case line
  dispatch_t  disp_q[$];
  wake_bus_t  wake_q[$];
  logic [1:0] ctl_q[$];        // {flush, div_busy}
  div_issue_t exp_issue_q[$];
  logic       exp_full_q[$];

  int errors;
  int checks;
  int cycle_cnt;
  int max_cycles;
  int cur_case;

  div_rs_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .dispatch (dispatch),
    .wake     (wake),
    .flush    (flush),
    .div_busy (div_busy),
    .issue    (issue),
    .full     (full)
  );

  always #20 clk = ~clk;

  task automatic finish_run();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // limit set from the number of case lines once they are loaded
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      errors++;
      finish_run();
    end
  end

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR: %s got 0x%0h expected 0x%0h in case %0d",
               name, got, exp, cur_case);
    end
  endtask

  task automatic load_cases(input int fd, output int bad);
    string       tok;
    string       rest;
    logic [31:0] f [30];
    int          code;
    bit          done;
    dispatch_t   d;
    wake_bus_t   w;
    div_issue_t  e;
    bad  = 0;
    done = 0;
    while (!done) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        done = 1;
      end else if (tok.getc(0) == "#") begin
        code = $fgets(rest, fd);  // rest of a comment line
      end else begin
        code = $sscanf(tok, "%h", f[0]);
        if (code != 1) begin
          bad++;
        end
        for (int k = 1; k < 30; k++) begin
          code = $fscanf(fd, "%h", f[k]);
          if (code != 1) begin
            bad++;
          end
        end
        d.start        = f[0][0];
        d.payload.pc   = f[1];
        d.payload.rd   = f[2][7:0];
        d.payload.op   = f[3][3:0];
        d.payload.src1 = f[4][7:0];
        d.payload.src2 = f[5][7:0];
        d.src_ready    = f[6][1:0];
        for (int p = 0; p < NUM_WAKE; p++) begin
          w[p].valid = f[7 + 2 * p][0];
          w[p].tag   = f[8 + 2 * p][7:0];
        end
        e.valid        = f[23][0];
        e.payload.pc   = f[24];
        e.payload.rd   = f[25][7:0];
        e.payload.op   = f[26][3:0];
        e.payload.src1 = f[27][7:0];
        e.payload.src2 = f[28][7:0];
        disp_q.push_back(d);
        wake_q.push_back(w);
        ctl_q.push_back({f[21][0], f[22][0]});
        exp_issue_q.push_back(e);
        exp_full_q.push_back(f[29][0]);
      end
    end
  endtask

  task automatic apply_case(input int i);
    dispatch_t d;
    d = disp_q[i];
    if (!d.start) begin
      d.payload.pc = $urandom;  // don't care while idle
    end
    dispatch = d;
    wake     = wake_q[i];
    flush    = ctl_q[i][1];
    div_busy = ctl_q[i][0];
  endtask

  task automatic check_case(input int i);
    div_issue_t e;
    e = exp_issue_q[i];
    check_val("issue.valid", issue.valid, e.valid);
    if (e.valid) begin
      check_val("issue.pc", issue.payload.pc, e.payload.pc);
      check_val("issue.rd", issue.payload.rd, e.payload.rd);
      check_val("issue.op", issue.payload.op, e.payload.op);
      check_val("issue.src1", issue.payload.src1, e.payload.src1);
      check_val("issue.src2", issue.payload.src2, e.payload.src2);
    end
    check_val("full", full, exp_full_q[i]);
  endtask

  initial begin
    int fd;
    int bad;
    clk        = 1'b0;
    rst_n      = 1'b0;
    dispatch   = '0;
    wake       = '0;
    flush      = 1'b0;
    div_busy   = 1'b0;
    errors     = 0;
    checks     = 0;
    cycle_cnt  = 0;
    max_cycles = 50;
    cur_case   = 0;
    void'($urandom(32'h838e4bf7));
    fd = $fopen("tb/div_rs_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file tb/div_rs_cases.txt");
      errors++;
      finish_run();
    end else begin
      load_cases(fd, bad);
      $fclose(fd);
      if (bad != 0) begin
        $display("case file has %0d fields that could not be read", bad);
        errors++;
      end
      if (disp_q.size() == 0) begin
        $display("case file holds no cases");
        errors++;
      end
      max_cycles = disp_q.size() + 50;
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;
      for (int i = 0; i < disp_q.size(); i++) begin
        cur_case = i;
        apply_case(i);
        #36;  // just before the next rising edge
        check_case(i);
        @(posedge clk);
        #2;
      end
      dispatch = '0;
      wake     = '0;
      flush    = 1'b0;
      div_busy = 1'b0;
      finish_run();
    end
  end

endmodule

//--- verilog.f
common/div_pkg.sv
div_rs/div_rs_select.sv
div_rs/div_rs_store.sv
div_rs/div_rs_wakeup.sv
div_rs/div_rs_ctrl.sv
hw/div_rs_top.sv
tb/div_rs_sva.sv
tb/div_rs_tb.sv
